// File: common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // Byte address width of the fetch bus and the program counter
  localparam int addr_width = 32;

  // First fetch starts one word into the image
  localparam logic [addr_width-1:0] reset_vector = 32'h0000_0004;

  // Program counter increments
  localparam logic [addr_width-1:0] half_step = 32'd2; // Compressed instruction
  localparam logic [addr_width-1:0] word_step = 32'd4; // Full 32-bit instruction

  // Fetch sequencer states
  typedef enum logic [1:0] {
    fetch_word  = 2'd0, // Request the word that holds pc
    fetch_upper = 2'd1, // Second beat of an instruction that crosses a word
    wait_decode = 2'd2  // Instruction presented, waiting for decode
  } fetch_state_t;

  // A bus word is either one full instruction or two halfwords
  typedef union packed {
    logic [31:0] full;     // Aligned 32-bit instruction
    struct packed {
      logic [15:0] hi;     // Halfword at byte offset 2
      logic [15:0] lo;     // Halfword at byte offset 0
    } half;
  } fetch_word_t;

  // Low bits 2'b11 mark a 32-bit encoding, anything else is compressed
  function automatic logic is_compressed(input logic [15:0] halfword);
    return (halfword[1:0] != 2'b11);
  endfunction

endpackage

`default_nettype wire

// File: fetch/fetch_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_fsm (
  input  logic        clock,
  input  logic        reset,
  input  logic        redirect,
  input  logic [31:0] pc,
  input  logic        iready,
  input  logic        decode_complete,
  input  logic        next_c,          // Halfword at pc is compressed
  input  logic        spare_valid,     // Spare buffer holds the next halfword
  input  logic        spare_c,         // Spare halfword is compressed
  output logic        ivalid,
  output logic [31:0] iaddr,
  output logic        fetch_valid,
  output logic        load_full,
  output logic        load_lo_half,
  output logic        load_hi_half,
  output logic        load_from_spare,
  output logic        spare_clear,
  output logic        pc_step
);

  fetch_pkg::fetch_state_t state;
  logic fetch_valid_r;  // Instruction register holds an unconsumed instruction
  logic beat;           // Bus access completes this cycle
  logic straddle;       // 32-bit instruction starting in the upper half
  logic spare_hit;      // Next instruction can come from the spare buffer
  logic instr_is_c;     // Instruction being presented is compressed

  assign beat      = ivalid && iready;
  assign straddle  = pc[1] && !next_c;
  // Spare is only ever valid when it sits at the next sequential pc
  assign spare_hit = instr_is_c && spare_valid && spare_c;

  // Word address of pc, or the following word for the second beat
  assign iaddr = (state == fetch_pkg::fetch_upper) ? {pc[31:2] + 30'd1, 2'b00}
                                                  : {pc[31:2], 2'b00};

  // Decode sees valid drop in the cycle it accepts
  assign fetch_valid = fetch_valid_r && !decode_complete;

  // Aligner and pc strobes
  always_comb begin
    load_full       = 1'b0;
    load_lo_half    = 1'b0;
    load_hi_half    = 1'b0;
    load_from_spare = 1'b0;
    spare_clear     = redirect; // Spare is stale after a jump
    pc_step         = 1'b0;
    if (!redirect) begin
      case (state)
        fetch_pkg::fetch_word: begin
          if (beat) begin
            load_full    = !pc[1] && !next_c;  // Aligned 32-bit
            load_lo_half = pc[1] || next_c;    // Compressed, or first half of straddle
          end
        end
        fetch_pkg::fetch_upper: begin
          load_hi_half = beat;                 // Upper 16 bits from the next word
        end
        fetch_pkg::wait_decode: begin
          if (decode_complete) begin
            pc_step         = 1'b1;
            load_from_spare = spare_hit;
            spare_clear     = !spare_hit;      // Going back to the bus
          end
        end
        default: begin
          spare_clear = 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= fetch_pkg::fetch_word;
      ivalid        <= 1'b0;
      fetch_valid_r <= 1'b0;
      instr_is_c    <= 1'b0;
    end else if (redirect) begin
      // Abandon whatever is in flight, restart at the new pc
      state         <= fetch_pkg::fetch_word;
      ivalid        <= 1'b0;
      fetch_valid_r <= 1'b0;
    end else begin
      case (state)
        fetch_pkg::fetch_word: begin
          if (!ivalid) begin
            ivalid <= 1'b1;                     // Start request, address follows pc
          end else if (iready) begin
            if (straddle) begin
              state <= fetch_pkg::fetch_upper;  // Keep ivalid, iaddr moves on
            end else begin
              ivalid        <= 1'b0;
              fetch_valid_r <= 1'b1;
              instr_is_c    <= next_c;
              state         <= fetch_pkg::wait_decode;
            end
          end
        end
        fetch_pkg::fetch_upper: begin
          if (beat) begin
            ivalid        <= 1'b0;
            fetch_valid_r <= 1'b1;
            instr_is_c    <= 1'b0;              // Crossing instruction is always 32-bit
            state         <= fetch_pkg::wait_decode;
          end
        end
        fetch_pkg::wait_decode: begin
          if (decode_complete) begin
            if (spare_hit) begin
              fetch_valid_r <= 1'b1;            // Next instruction without a bus beat
              instr_is_c    <= 1'b1;
            end else begin
              // pc has advanced by the time ivalid is seen
              fetch_valid_r <= 1'b0;
              ivalid        <= 1'b1;
              state         <= fetch_pkg::fetch_word;
            end
          end
        end
        default: begin
          ivalid        <= 1'b0;
          fetch_valid_r <= 1'b0;
          state         <= fetch_pkg::fetch_word;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: fetch/fetch_align.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_align (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] pc,
  input  logic [31:0] idata,
  input  logic        load_full,        // Whole word is the instruction
  input  logic        load_lo_half,     // Halfword at pc into instr[15:0]
  input  logic        load_hi_half,     // Low half of the next word into instr[31:16]
  input  logic        load_from_spare,  // Spare halfword becomes the instruction
  input  logic        spare_clear,
  output logic        next_c,
  output logic        spare_valid,
  output logic        spare_c,
  output logic [31:0] instr,
  output logic        instr_c
);

  fetch_pkg::fetch_word_t word;   // Bus word in both views
  logic [15:0] pc_half;           // Halfword selected by pc[1]
  logic [15:0] spare_half;        // Unused halfword of the last word

  assign word    = idata;
  assign pc_half = pc[1] ? word.half.hi : word.half.lo;

  // Length decode for the FSM
  assign next_c  = fetch_pkg::is_compressed(pc_half);
  assign spare_c = fetch_pkg::is_compressed(spare_half);

  // Instruction register
  always_ff @(posedge clock) begin
    if (load_full) begin
      instr <= word.full;
    end else if (load_lo_half) begin
      instr <= {16'h0000, pc_half};       // Upper bits filled by a later beat if needed
    end else if (load_hi_half) begin
      instr[31:16] <= word.half.lo;
    end else if (load_from_spare) begin
      instr <= {16'h0000, spare_half};
    end
  end

  // Spare halfword, always the high half of the word just fetched
  always_ff @(posedge clock) begin
    if ((load_lo_half && !pc[1]) || load_hi_half) begin
      spare_half <= word.half.hi;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      instr_c     <= 1'b0;
      spare_valid <= 1'b0;
    end else begin
      if (load_full || load_hi_half) begin
        instr_c <= 1'b0;
      end else if (load_lo_half) begin
        instr_c <= next_c;                // Low for the first half of a straddle
      end else if (load_from_spare) begin
        instr_c <= 1'b1;
      end

      if (spare_clear || load_full || load_from_spare) begin
        spare_valid <= 1'b0;
      end else if (load_lo_half) begin
        spare_valid <= !pc[1];            // Low half taken, high half left over
      end else if (load_hi_half) begin
        spare_valid <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/pc_counter.sv
`timescale 1ns/1ps
`default_nettype none

module pc_counter (
  input  logic        clock,
  input  logic        reset,
  input  logic        redirect,
  input  logic [31:0] redirect_pc,
  input  logic        pc_step,     // Current instruction accepted by decode
  input  logic        instr_c,     // Current instruction is compressed
  output logic [31:0] pc
);

  logic [31:0] step;         // Byte length of the current instruction
  logic [31:0] target;       // Redirect address on a halfword boundary

  assign step   = instr_c ? fetch_pkg::half_step : fetch_pkg::word_step;
  assign target = {redirect_pc[31:1], 1'b0};

  // Redirect wins over a step in the same cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= fetch_pkg::reset_vector;
    end else if (redirect) begin
      pc <= target;
    end else if (pc_step) begin
      pc <= pc + step;       // Sequential advance
    end
  end

endmodule

`default_nettype wire

// File: hdl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  logic        clock,
  input  logic        reset,
  input  logic        redirect,
  input  logic [31:0] redirect_pc,
  output logic [31:0] iaddr,
  output logic        ivalid,
  input  logic [31:0] idata,
  input  logic        iready,
  output logic [31:0] instr,
  output logic        instr_c,
  output logic        fetch_valid,
  input  logic        decode_complete
);

  logic [31:0] pc;
  logic        pc_step;
  logic        next_c;           // Length of the halfword at pc on the bus
  logic        spare_valid;
  logic        spare_c;
  logic        load_full;
  logic        load_lo_half;
  logic        load_hi_half;
  logic        load_from_spare;
  logic        spare_clear;

  // Sequencer for bus beats and aligner loads
  fetch_fsm i_fsm (
    .clock           (clock),
    .reset           (reset),
    .redirect        (redirect),
    .pc              (pc),
    .iready          (iready),
    .decode_complete (decode_complete),
    .next_c          (next_c),
    .spare_valid     (spare_valid),
    .spare_c         (spare_c),
    .ivalid          (ivalid),
    .iaddr           (iaddr),
    .fetch_valid     (fetch_valid),
    .load_full       (load_full),
    .load_lo_half    (load_lo_half),
    .load_hi_half    (load_hi_half),
    .load_from_spare (load_from_spare),
    .spare_clear     (spare_clear),
    .pc_step         (pc_step)
  );

  // Instruction register and spare halfword
  fetch_align i_align (
    .clock           (clock),
    .reset           (reset),
    .pc              (pc),
    .idata           (idata),
    .load_full       (load_full),
    .load_lo_half    (load_lo_half),
    .load_hi_half    (load_hi_half),
    .load_from_spare (load_from_spare),
    .spare_clear     (spare_clear),
    .next_c          (next_c),
    .spare_valid     (spare_valid),
    .spare_c         (spare_c),
    .instr           (instr),
    .instr_c         (instr_c)
  );

  pc_counter i_pc (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pc_step     (pc_step),
    .instr_c     (instr_c),      // Step size follows the instruction just accepted
    .pc          (pc)
  );

endmodule

`default_nettype wire

// File: tests/fetch_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_mem_model (
  input  logic        clock,
  input  logic [31:0] iaddr,
  input  logic        ivalid,
  output logic [31:0] idata,
  output logic        iready
);

  logic [15:0] image [0:511];   // 1 KiB program image, indexed by byte address bits 9:1
  integer      seed;
  logic [31:0] r;
  fetch_pkg::fetch_word_t word; // Bus word assembled from two halfwords

  // Random mix of compressed and 32-bit halfwords, then a directed head
  initial begin
    seed   = 32'h158c5c7a;
    iready = 1'b0;
    for (int i = 0; i < 512; i++) begin
      r = $random(seed);
      if (r[16]) begin
        r[1:0] = 2'b11;          // Start of a 32-bit encoding
      end else if (r[1:0] == 2'b11) begin
        r[1:0] = 2'b01;          // Keep it compressed
      end
      image[i] = r[15:0];
    end
    image[2]  = 16'h8513;        // Aligned 32-bit at byte 4
    image[3]  = 16'h0015;
    image[4]  = 16'h0613;        // Aligned 32-bit at byte 8
    image[5]  = 16'h00a6;
    image[6]  = 16'h4505;        // Compressed pair in the word at byte 12
    image[7]  = 16'h0505;
    image[8]  = 16'h4581;        // Compressed at byte 16
    image[9]  = 16'h0713;        // 32-bit crossing into the word at byte 20
    image[10] = 16'h0207;
  end

  assign word.half.lo = image[{iaddr[9:2], 1'b0}];
  assign word.half.hi = image[{iaddr[9:2], 1'b1}];
  assign idata        = ivalid ? word.full : 'x;  // Data only driven during a request

  // Ready three cycles in four, at random
  always @(posedge clock) begin
    iready <= ($random(seed) & 3) != 0;
  end

endmodule

`default_nettype wire

// File: tests/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

  localparam int total_instrs = 1 + 1 + 2 + 2 + 20 + 200;
  localparam int max_stall    = 16;
  // Two beats per instruction at worst, plus decode delay, doubled
  localparam int cycle_limit  = 2 * (total_instrs * 2 * max_stall + total_instrs * 4) + 1000;

  logic        clock;
  logic        reset;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic [31:0] iaddr;
  logic        ivalid;
  logic [31:0] idata;
  logic        iready;
  logic [31:0] instr;
  logic        instr_c;
  logic        fetch_valid;
  logic        decode_complete;

  integer      seed;
  int          errors;
  int          tests_ok;
  int          tests_bad;
  int          cycles;
  logic [31:0] ref_pc;       // Reference stream position
  logic        ref_spare;    // Reference copy of the spare buffer flag
  logic        ref_last_c;   // Last accepted instruction was compressed
  int          beats;        // Bus beats since the last accept or redirect
  logic [31:0] last_addr;
  logic        ivalid_seen;
  fetch_pkg::fetch_state_t state_now;

  fetch_top i_dut (
    .clock           (clock),
    .reset           (reset),
    .redirect        (redirect),
    .redirect_pc     (redirect_pc),
    .iaddr           (iaddr),
    .ivalid          (ivalid),
    .idata           (idata),
    .iready          (iready),
    .instr           (instr),
    .instr_c         (instr_c),
    .fetch_valid     (fetch_valid),
    .decode_complete (decode_complete)
  );

  fetch_mem_model i_mem (
    .clock  (clock),
    .iaddr  (iaddr),
    .ivalid (ivalid),
    .idata  (idata),
    .iready (iready)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Bus activity between decode accepts
  always @(posedge clock) begin
    if (reset || decode_complete || redirect) begin
      beats       <= 0;
      ivalid_seen <= 1'b0;
    end else begin
      if (ivalid) ivalid_seen <= 1'b1;
      if (ivalid && iready) begin
        beats     <= beats + 1;
        last_addr <= iaddr;
      end
    end
  end

  a_iaddr_aligned: assert property (@(posedge clock) disable iff (reset)
    ivalid |-> iaddr[1:0] == 2'b00)
    else begin
      errors++;
      $display("MISMATCH at %0t: unaligned iaddr %h", $time, iaddr);
    end

  a_instr_stable: assert property (@(posedge clock) disable iff (reset)
    fetch_valid |=> $stable(instr) && $stable(instr_c))
    else begin
      errors++;
      $display("MISMATCH at %0t: instr changed while presented", $time);
    end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      state_now = i_dut.i_fsm.state;
      $display("Timeout: run limit of %0d cycles reached in state %s", cycle_limit,
               state_now.name());
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic logic [15:0] half_at(input logic [31:0] addr);
    return i_mem.image[addr[9:1]];
  endfunction

  // Accept n instructions and compare each with the reference walk
  task automatic run_instrs(input int n, input bit random_delay);
    logic [15:0] h;
    logic [31:0] exp_instr;
    logic        exp_c;
    logic        hit;
    logic        straddle;
    int          wait_cnt;
    int          delay;
    for (int i = 0; i < n; i++) begin
      h         = half_at(ref_pc);
      exp_c     = h[1:0] != 2'b11;
      exp_instr = exp_c ? {16'h0000, h} : {half_at(ref_pc + 2), h};
      hit       = ref_spare && ref_last_c && exp_c;  // Reuse only after a compressed one
      straddle  = ref_pc[1] && !exp_c;
      wait_cnt  = 0;
      @(negedge clock);
      while (!fetch_valid && wait_cnt < 400) begin
        wait_cnt++;
        @(negedge clock);
      end
      if (!fetch_valid) begin
        errors++;
        $display("fetch_valid never rose for the instruction at pc %h", ref_pc);
        return;
      end
      assert (instr == exp_instr && instr_c == exp_c)
        else begin
          errors++;
          $display("MISMATCH at %0t: pc %h instr %h c %0b, expected %h c %0b", $time,
                   ref_pc, instr, instr_c, exp_instr, exp_c);
        end
      if (hit) begin
        assert (!ivalid_seen && beats == 0)
          else begin
            errors++;
            $display("MISMATCH at %0t: spare hit at pc %h used the bus", $time, ref_pc);
          end
      end else if (straddle) begin
        assert (beats == 2 && last_addr == {ref_pc[31:2], 2'b00} + 32'd4)
          else begin
            errors++;
            $display("MISMATCH at %0t: pc %h took %0d beats, last at %h", $time, ref_pc,
                     beats, last_addr);
          end
      end else begin
        assert (beats == 1 && last_addr == {ref_pc[31:2], 2'b00})
          else begin
            errors++;
            $display("MISMATCH at %0t: pc %h took %0d beats at %h", $time, ref_pc, beats,
                     last_addr);
          end
      end
      // Spare is left over by a low-half compressed load or a crossing instruction
      if (hit) ref_spare = 1'b0;
      else ref_spare = straddle || (exp_c && !ref_pc[1]);
      ref_last_c = exp_c;
      ref_pc = ref_pc + (exp_c ? 32'd2 : 32'd4);
      delay = random_delay ? ($random(seed) & 3) : 0;
      repeat (delay) @(negedge clock);
      @(posedge clock);
      decode_complete <= 1'b1;
      @(posedge clock);
      decode_complete <= 1'b0;
    end
  endtask

  task automatic jump_to(input logic [31:0] target);
    @(posedge clock);
    redirect    <= 1'b1;
    redirect_pc <= target;
    @(posedge clock);
    redirect    <= 1'b0;
    ref_pc    = {target[31:1], 1'b0};
    ref_spare = 1'b0;
  endtask

  task automatic report(input string name, input int errs_before);
    if (errors == errs_before) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  initial begin
    int e0;
    seed            = 32'h158c5c7a;
    errors          = 0;
    tests_ok        = 0;
    tests_bad       = 0;
    cycles          = 0;
    reset           = 1'b1;
    redirect        = 1'b0;
    redirect_pc     = 32'h0;
    decode_complete = 1'b0;
    ref_pc          = fetch_pkg::reset_vector;
    ref_spare       = 1'b0;
    ref_last_c      = 1'b0;
    repeat (3) @(posedge clock);
    reset <= 1'b0;

    e0 = errors;
    @(negedge clock);
    assert (!ivalid && !fetch_valid)
      else begin
        errors++;
        $display("MISMATCH at %0t: ivalid or fetch_valid high after reset", $time);
      end
    run_instrs(1, 1'b0);       // First beat must be at the reset vector
    report("reset", e0);

    e0 = errors;
    run_instrs(1, 1'b0);
    report("aligned", e0);

    e0 = errors;
    run_instrs(2, 1'b0);
    report("compressed_pair", e0);

    e0 = errors;
    run_instrs(2, 1'b0);
    report("straddle", e0);

    e0 = errors;
    jump_to(32'h0000_0106);
    run_instrs(20, 1'b0);
    report("redirect", e0);

    e0 = errors;
    run_instrs(200, 1'b1);
    report("random", e0);

    $display("tests ok %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
common/fetch_pkg.sv
fetch/fetch_fsm.sv
fetch/fetch_align.sv
hdl/pc_counter.sv
hdl/fetch_top.sv
tests/fetch_mem_model.sv
tests/fetch_tb.sv

// File: Makefile
# Verilator build for the instruction fetch unit

VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= fetch_tb
RTL_TOP   ?= fetch_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint lint_rtl sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

lint_rtl:
	$(VERILATOR) --lint-only -Wall common/fetch_pkg.sv fetch/fetch_fsm.sv \
		fetch/fetch_align.sv hdl/pc_counter.sv hdl/fetch_top.sv --top-module $(RTL_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
